// File: flash_params.svh
`ifndef FLASH_PARAMS_SVH
`define FLASH_PARAMS_SVH

// APB byte address where the flash window starts
`define FLASH_BASE 32'h1000_0000

`define FLASH_SIZE 32'h0000_1000         // window size in bytes, power of two

`define FLASH_WAIT_CYCLES 3              // cycles per halfword before sampling, >= 1

// flash byte address width follows the window size
`define FLASH_ADDR_W $clog2(`FLASH_SIZE)

`endif

// File: flash_pkg.sv
`include "flash_params.svh"

package flash_pkg;

    localparam int WORD_W = 32;
    localparam int HALF_W = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [HALF_W-1:0] halfword_t;
    typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t;

    // controller sequence, one pass per APB read
    typedef enum logic [1:0] {
        idle,
        read_lo,                        // address at offset, low halfword
        read_hi,                        // address at offset + 2, high halfword
        done                            // word ready for the bridge
    } flash_state_t;

    typedef struct packed {
        logic        valid;             // single-cycle start pulse
        flash_addr_t addr;              // byte offset into the window
    } flash_req_t;

    typedef struct packed {
        flash_addr_t a;
        logic        ce_n;
        logic        oe_n;
        logic        we_n;
        logic        rp_n;
        logic        vpen;
        logic        byte_n;
    } flash_pins_t;

endpackage

// File: flash_apb_bridge.sv
`include "flash_params.svh"

module flash_apb_bridge (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  flash_pkg::word_t       paddr,
    input  flash_pkg::word_t       pwdata,     // no write path behind this port
    output flash_pkg::word_t       prdata,
    output logic                   pready,
    output logic                   pslverr,
    output flash_pkg::flash_req_t  req,
    input  logic                   done,
    input  flash_pkg::word_t       rdata
);

    typedef enum logic [1:0] {
        br_idle,
        br_wait,                        // read issued, controller running
        br_resp                         // pready high for one cycle
    } br_state_t;

    br_state_t              state;
    flash_pkg::word_t       offset;
    flash_pkg::flash_addr_t req_addr;
    logic                   req_valid;
    logic                   access;
    logic                   in_window;
    logic                   aligned;
    logic                   bad;

    assign access    = psel && penable && !pready;     // first access-phase cycle
    assign offset    = paddr - `FLASH_BASE;
    assign in_window = offset < `FLASH_SIZE;           // also catches paddr below base
    assign aligned   = paddr[1:0] == 2'b00;
    assign bad       = pwrite || !aligned || !in_window;

    assign req = '{valid: req_valid, addr: req_addr};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= br_idle;
            req_valid <= 1'b0;
            pready    <= 1'b0;
            pslverr   <= 1'b0;
            prdata    <= '0;
        end else begin
            req_valid <= 1'b0;          // pulse lasts one cycle
            case (state)
                br_idle: begin
                    if (access) begin
                        if (bad) begin
                            pready  <= 1'b1;
                            pslverr <= 1'b1;
                            prdata  <= '0;
                            state   <= br_resp;
                        end else begin
                            req_valid <= 1'b1;
                            state     <= br_wait;
                        end
                    end
                end
                br_wait: begin
                    if (done) begin
                        prdata  <= rdata;   // held until the transfer ends
                        pready  <= 1'b1;
                        pslverr <= 1'b0;
                        state   <= br_resp;
                    end
                end
                br_resp: begin
                    pready  <= 1'b0;
                    pslverr <= 1'b0;
                    state   <= br_idle;
                end
                default: begin
                    state <= br_idle;
                end
            endcase
        end
    end

    // window offset of the accepted read
    always_ff @(posedge clk) begin
        if (state == br_idle && access && !bad) begin
            req_addr <= offset[`FLASH_ADDR_W-1:0];
        end
    end

endmodule

// File: flash_controller.sv
`include "flash_params.svh"

module flash_controller (
    input  logic                   clk,
    input  logic                   rst,
    input  flash_pkg::flash_req_t  req,
    output logic                   done,
    output flash_pkg::word_t       rdata,
    output flash_pkg::flash_pins_t flash_o,
    input  flash_pkg::halfword_t   flash_d
);

    localparam int CNT_W = $clog2(`FLASH_WAIT_CYCLES + 1);
    localparam logic [CNT_W-1:0] WAIT_LOAD = CNT_W'(`FLASH_WAIT_CYCLES - 1);

    flash_pkg::flash_state_t state;
    flash_pkg::flash_addr_t  a_q;
    flash_pkg::word_t        rdata_q;
    logic [CNT_W-1:0]        wait_cnt;
    logic                    sel_n;                 // drives both ce_n and oe_n
    logic                    last_cycle;
    logic                    cap_lo;
    logic                    cap_hi;

    assign last_cycle = wait_cnt == '0;
    assign cap_lo     = (state == flash_pkg::read_lo) && last_cycle;
    assign cap_hi     = (state == flash_pkg::read_hi) && last_cycle;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= flash_pkg::idle;
            wait_cnt <= '0;
            a_q      <= '0;
            sel_n    <= 1'b1;
        end else begin
            case (state)
                flash_pkg::idle: begin
                    if (req.valid) begin                // only taken when not busy
                        a_q      <= req.addr;
                        sel_n    <= 1'b0;
                        wait_cnt <= WAIT_LOAD;
                        state    <= flash_pkg::read_lo;
                    end
                end
                flash_pkg::read_lo: begin
                    if (last_cycle) begin
                        a_q      <= a_q + flash_pkg::flash_addr_t'(2);  // next halfword
                        wait_cnt <= WAIT_LOAD;
                        state    <= flash_pkg::read_hi;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                flash_pkg::read_hi: begin
                    if (last_cycle) begin
                        sel_n <= 1'b1;                  // release the chip
                        state <= flash_pkg::done;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                flash_pkg::done: begin
                    state <= flash_pkg::idle;
                end
                default: begin
                    state <= flash_pkg::idle;
                end
            endcase
        end
    end

    // halfword capture at the end of each access window
    always_ff @(posedge clk) begin
        if (cap_lo) begin
            rdata_q[15:0] <= flash_d;
        end
        if (cap_hi) begin
            rdata_q[31:16] <= flash_d;
        end
    end

    assign done  = state == flash_pkg::done;
    assign rdata = rdata_q;

    assign flash_o = '{
        a:      a_q,
        ce_n:   sel_n,
        oe_n:   sel_n,
        we_n:   1'b1,                   // never programmed
        rp_n:   1'b1,                   // keep the part out of reset
        vpen:   1'b1,
        byte_n: 1'b1                    // 16-bit bus mode
    };

endmodule

// File: flash_top.sv
module flash_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  flash_pkg::word_t       paddr,
    input  flash_pkg::word_t       pwdata,
    output flash_pkg::word_t       prdata,
    output logic                   pready,
    output logic                   pslverr,
    output flash_pkg::flash_pins_t flash_o,
    input  flash_pkg::halfword_t   flash_d
);

    flash_pkg::flash_req_t req;
    flash_pkg::word_t      rdata;
    logic                  done;

    flash_apb_bridge bridge0 (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (req),
        .done    (done),
        .rdata   (rdata)
    );

    flash_controller ctrl0 (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .done    (done),
        .rdata   (rdata),
        .flash_o (flash_o),
        .flash_d (flash_d)
    );

endmodule

// File: flash_model.sv
`include "flash_params.svh"

module flash_model (
    input  flash_pkg::flash_pins_t pins,
    output flash_pkg::halfword_t   d
);

    localparam int DEPTH = `FLASH_SIZE / 2;         // halfwords in the part

    flash_pkg::halfword_t mem [DEPTH];
    logic                 selected;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 16'((2 * i) * 3) ^ 16'hA5C3;  // byte address times 3
        end
    end

    assign selected = !pins.ce_n && !pins.oe_n;

    // bus floats to a marker value while the part is not driving it
    assign d = selected ? mem[pins.a[`FLASH_ADDR_W-1:1]] : 16'hDEAD;

endmodule

// File: flash_top_sva.sv
`include "flash_params.svh"

module flash_top_sva (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  flash_pkg::word_t        paddr,
    input  logic                    pready,
    input  logic                    pslverr,
    input  flash_pkg::flash_req_t   req,
    input  flash_pkg::flash_pins_t  flash_o,
    input  flash_pkg::flash_state_t ctrl_state
);

    localparam int W      = `FLASH_WAIT_CYCLES;
    localparam int RD_LAT = 2 * W + 3;              // first access cycle to pready

    int               fail_cnt = 0;
    logic             first_acc;
    logic             rejected;
    logic             busy;
    flash_pkg::word_t offset;

    assign first_acc = psel && penable && !pready;
    assign offset    = paddr - `FLASH_BASE;
    assign rejected  = pwrite || paddr[1:0] != 2'b00 || offset >= `FLASH_SIZE;
    assign busy      = ctrl_state != flash_pkg::idle;

    tie_high: assert property (@(posedge clk)
        flash_o.we_n && flash_o.rp_n && flash_o.vpen && flash_o.byte_n)
        else begin fail_cnt++; $error("flash pin ties not all high"); end

    reset_idle: assert property (@(posedge clk) rst && $past(rst) |->
        !pready && !pslverr && flash_o.ce_n && flash_o.oe_n && flash_o.a == '0)
        else begin fail_cnt++; $error("outputs not idle in reset"); end

    oe_in_ce: assert property (@(posedge clk) disable iff (rst)
        !flash_o.oe_n |-> !flash_o.ce_n)
        else begin fail_cnt++; $error("oe_n low while ce_n high"); end

    // chip select follows the two read states exactly
    ce_by_state: assert property (@(posedge clk) disable iff (rst)
        (ctrl_state == flash_pkg::read_lo || ctrl_state == flash_pkg::read_hi)
        == !flash_o.ce_n)
        else begin fail_cnt++; $error("ce_n out of step with controller state"); end

    lo_window: assert property (@(posedge clk) disable iff (rst)
        ctrl_state == flash_pkg::read_hi && $past(ctrl_state) == flash_pkg::read_lo |->
        $past(ctrl_state, W) == flash_pkg::read_lo &&
        $past(ctrl_state, W + 1) != flash_pkg::read_lo &&
        $past(flash_o.a) == $past(flash_o.a, W))
        else begin fail_cnt++; $error("low halfword window wrong"); end

    hi_step: assert property (@(posedge clk) disable iff (rst)
        ctrl_state == flash_pkg::read_hi && $past(ctrl_state) == flash_pkg::read_lo |->
        flash_o.a == $past(flash_o.a) + flash_pkg::flash_addr_t'(2))
        else begin fail_cnt++; $error("second address not first plus 2"); end

    hi_window: assert property (@(posedge clk) disable iff (rst)
        ctrl_state == flash_pkg::done |->
        $past(ctrl_state, W) == flash_pkg::read_hi &&
        $past(ctrl_state, W + 1) == flash_pkg::read_lo &&
        $past(flash_o.a) == $past(flash_o.a, W))
        else begin fail_cnt++; $error("high halfword window wrong"); end

    read_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(pready) && !pslverr |->
        $past(first_acc, RD_LAT) && !$past(rejected, RD_LAT))
        else begin fail_cnt++; $error("read pready latency wrong"); end

    err_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(pready) && pslverr |-> $past(first_acc) && $past(rejected))
        else begin fail_cnt++; $error("error response latency wrong"); end

    reject_quiet: assert property (@(posedge clk) disable iff (rst)
        first_acc && rejected |=> flash_o.ce_n && flash_o.oe_n && !req.valid)
        else begin fail_cnt++; $error("flash activity on a rejected access"); end

    err_quiet: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> flash_o.ce_n && flash_o.oe_n)
        else begin fail_cnt++; $error("flash selected during error response"); end

    req_when_idle: assert property (@(posedge clk) disable iff (rst)
        req.valid |-> !busy)
        else begin fail_cnt++; $error("request sent while controller busy"); end

endmodule

bind flash_top flash_top_sva sva0 (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pready     (pready),
    .pslverr    (pslverr),
    .req        (req),
    .flash_o    (flash_o),
    .ctrl_state (ctrl0.state)
);

// File: tb_flash_top.sv
`include "flash_params.svh"

module tb_flash_top;

    localparam int W           = `FLASH_WAIT_CYCLES;
    localparam int RD_LAT      = 2 * W + 3;         // falling edges from penable to pready
    localparam int NUM_RAND    = 20;
    localparam int NUM_XFERS   = 1 + 3 + NUM_RAND;
    localparam int XFER_MAX    = RD_LAT + 2;        // setup cycle and completion edge
    localparam int CYCLE_LIMIT = 7 + NUM_XFERS * XFER_MAX + 40;

    logic                   clk;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    flash_pkg::word_t       paddr;
    flash_pkg::word_t       pwdata;
    flash_pkg::word_t       prdata;
    logic                   pready;
    logic                   pslverr;
    flash_pkg::flash_pins_t flash_o;
    flash_pkg::halfword_t   flash_d;

    int seed;
    int cycles = 0;
    int tests_run;
    int tests_failed;
    int sva_seen;

    flash_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .flash_o (flash_o),
        .flash_d (flash_d)
    );

    flash_model model0 (
        .pins (flash_o),
        .d    (flash_d)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // expected flash contents at a byte offset
    function automatic flash_pkg::halfword_t half_at(input int unsigned off);
        return 16'(off * 3) ^ 16'hA5C3;
    endfunction

    task automatic apb_xfer(input logic wr, input flash_pkg::word_t addr,
                            input flash_pkg::word_t wdata, output flash_pkg::word_t data,
                            output logic err, output int lat);
        @(negedge clk);
        psel    = 1'b1;                     // setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        lat     = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!pready);
        data = prdata;
        err  = pslverr;
    endtask

    task automatic record_result(input string name, input logic ok);
        @(posedge clk);                     // transfer completes on this edge
        #1;
        tests_run++;
        if (!ok || dut0.sva0.fail_cnt != sva_seen) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
        sva_seen = dut0.sva0.fail_cnt;
    endtask

    task automatic check_read(input flash_pkg::word_t off, input string name);
        flash_pkg::word_t data;
        flash_pkg::word_t exp;
        logic             err;
        logic             ok;
        int               lat;
        exp = {half_at(off + 2), half_at(off)};     // low halfword first
        apb_xfer(1'b0, `FLASH_BASE + off, '0, data, err, lat);
        ok = 1'b1;
        if (err !== 1'b0 || data !== exp) begin
            $display("ERROR at %0t: %s offset 0x%0h read 0x%08h err %b, expected 0x%08h",
                     $time, name, off, data, err, exp);
            ok = 1'b0;
        end
        if (lat != RD_LAT) begin
            $display("ERROR at %0t: %s pready after %0d cycles, expected %0d",
                     $time, name, lat, RD_LAT);
            ok = 1'b0;
        end
        record_result(name, ok);
    endtask

    task automatic check_reject(input logic wr, input flash_pkg::word_t addr,
                                input string name);
        flash_pkg::word_t data;
        logic             err;
        logic             ok;
        int               lat;
        apb_xfer(wr, addr, 32'h1234_5678, data, err, lat);
        ok = 1'b1;
        if (err !== 1'b1 || lat != 1) begin
            $display("ERROR at %0t: %s at 0x%08h gave err %b after %0d cycles",
                     $time, name, addr, err, lat);
            ok = 1'b0;
        end
        record_result(name, ok);
    endtask

    initial begin
        flash_pkg::word_t off;
        logic             ok;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        seed         = 51087;
        tests_run    = 0;
        tests_failed = 0;
        sva_seen     = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        ok = pready === 1'b0 && pslverr === 1'b0 && flash_o.ce_n === 1'b1 &&
             flash_o.oe_n === 1'b1 && flash_o.we_n === 1'b1 && flash_o.rp_n === 1'b1 &&
             flash_o.vpen === 1'b1 && flash_o.byte_n === 1'b1;
        if (!ok) begin
            $display("ERROR at %0t: outputs not in their reset state", $time);
        end
        record_result("reset_state", ok);

        check_read('0, "single_read");
        check_reject(1'b1, `FLASH_BASE, "write_reject");
        check_reject(1'b0, `FLASH_BASE + 2, "misaligned_reject");
        check_reject(1'b0, `FLASH_BASE + `FLASH_SIZE, "range_reject");

        for (int i = 0; i < NUM_RAND; i++) begin
            off = flash_pkg::word_t'($random(seed)) & (`FLASH_SIZE - 4);  // aligned offset
            check_read(off, $sformatf("random_read_%0d", i));
        end

        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        repeat (2) @(negedge clk);

        $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, dut0.sva0.fail_cnt);
        if (tests_failed == 0 && dut0.sva0.fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: flash_top.f
+incdir+.
flash_pkg.sv
flash_apb_bridge.sv
flash_controller.sv
flash_top.sv
flash_model.sv
flash_top_sva.sv
tb_flash_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the flash controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_flash_top -f flash_top.f -o sim_flash
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/sim_flash +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Test OK$"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
